// ==== verilog.f ====
+incdir+include
rtl/gat_pkg.sv
rtl/gat_param_store.sv
rtl/gat_projector.sv
rtl/gat_score_unit.sv
rtl/gat_wh_buffer.sv
rtl/gat_aggregator.sv
rtl/gat_layer.sv
test/tb_clock_gen.sv
test/tb_gat_layer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the GAT layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_gat_layer -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_gat_layer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  exit 0
fi
exit 1

// ==== test/tb_gat_layer.sv ====
`include "gat_config.svh"

module tb_gat_layer
  import gat_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic       clk;
  logic       rst_n;
  logic       param_we_i;
  param_sel_e param_sel_i;
  logic [3:0] param_addr_i;
  data_t      param_data_i;
  logic       node_vld_i;
  feat_vec_t  node_feat_i;
  logic       node_last_i;
  logic       feat_vld_o;
  wh_vec_t    feat_o;

  // Model copies of the parameter tables
  longint w_m [`GAT_F_IN][`GAT_F_OUT];
  longint a_self_m [`GAT_F_OUT];
  longint a_nbr_m [`GAT_F_OUT];
  int     pulse_cnt;
  int     sent_cnt;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_layer UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .param_we_i   (param_we_i),
    .param_sel_i  (param_sel_i),
    .param_addr_i (param_addr_i),
    .param_data_i (param_data_i),
    .node_vld_i   (node_vld_i),
    .node_feat_i  (node_feat_i),
    .node_last_i  (node_last_i),
    .feat_vld_o   (feat_vld_o),
    .feat_o       (feat_o)
  );

  always @(negedge clk) begin
    if (rst_n && feat_vld_o) begin
      pulse_cnt <= pulse_cnt + 1;
    end
  end

  function automatic data_t rand_data();
    return data_t'($urandom());
  endfunction

  // Projection, ReLU score against node 0, then weighted mean
  function automatic wh_vec_t model_result(input feat_vec_t nodes [`GAT_MAX_NODES],
                                           input int n);
    longint  wh [`GAT_MAX_NODES][`GAT_F_OUT];
    longint  score [`GAT_MAX_NODES];
    longint  acc [`GAT_F_OUT];
    longint  self_term;
    longint  sum;
    wh_vec_t res;
    self_term = 0;
    sum = 0;
    for (int j = 0; j < n; j++) begin
      for (int k = 0; k < `GAT_F_OUT; k++) begin
        wh[j][k] = 0;
        for (int i = 0; i < `GAT_F_IN; i++) begin
          wh[j][k] += longint'(nodes[j].f[i]) * w_m[i][k];
        end
      end
    end
    for (int k = 0; k < `GAT_F_OUT; k++) begin
      self_term += a_self_m[k] * wh[0][k];
      acc[k] = 0;
    end
    for (int j = 0; j < n; j++) begin
      score[j] = self_term;
      for (int k = 0; k < `GAT_F_OUT; k++) begin
        score[j] += a_nbr_m[k] * wh[j][k];
      end
      if (score[j] < 0) begin
        score[j] = 0;
      end
      sum += score[j];
      for (int k = 0; k < `GAT_F_OUT; k++) begin
        acc[k] += score[j] * wh[j][k];
      end
    end
    for (int k = 0; k < `GAT_F_OUT; k++) begin
      res.f[k] = (sum == 0) ? '0 : wh_t'(acc[k] / sum);
    end
    return res;
  endfunction

  task automatic check_feat(input wh_vec_t got, input wh_vec_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: feat_o got %h expected %h", $time, got, exp);
      $display("Checks failed");
      $fatal(1, "feat_o differs from the expected value");
    end
  endtask

  task automatic check_pulse_count(input int got, input int exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: feat_vld_o pulses got %0d expected %0d", $time, got, exp);
      $display("Checks failed");
      $fatal(1, "wrong number of result pulses");
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("Checks failed");
    $fatal(1, "run stopped on a timeout");
  endtask

  task automatic write_param(input param_sel_e sel, input int addr, input data_t d);
    @(posedge clk);
    param_we_i   <= 1'b1;
    param_sel_i  <= sel;
    param_addr_i <= 4'(addr);
    param_data_i <= d;
  endtask

  task automatic load_params(input bit zero_attn);
    data_t d;
    for (int a = 0; a < `GAT_F_IN * `GAT_F_OUT; a++) begin
      d = rand_data();
      w_m[a / `GAT_F_OUT][a % `GAT_F_OUT] = d;
      write_param(PARAM_W, a, d);
    end
    for (int k = 0; k < `GAT_F_OUT; k++) begin
      d = zero_attn ? data_t'(0) : rand_data();
      a_self_m[k] = d;
      write_param(PARAM_A_SELF, k, d);
      d = zero_attn ? data_t'(0) : rand_data();
      a_nbr_m[k] = d;
      write_param(PARAM_A_NBR, k, d);
    end
    @(posedge clk);
    param_we_i <= 1'b0;
  endtask

  task automatic run_subgraph(input int n, input bit expect_zero);
    feat_vec_t nodes [`GAT_MAX_NODES];
    wh_vec_t   exp_feat;
    int        waited;
    for (int j = 0; j < n; j++) begin
      for (int i = 0; i < `GAT_F_IN; i++) begin
        nodes[j].f[i] = rand_data();
      end
    end
    exp_feat = model_result(nodes, n);
    for (int j = 0; j < n; j++) begin
      @(posedge clk);
      node_vld_i  <= 1'b1;
      node_feat_i <= nodes[j];
      node_last_i <= (j == n - 1);
    end
    @(posedge clk);
    node_vld_i  <= 1'b0;
    node_last_i <= 1'b0;
    sent_cnt++;
    waited = 0;
    while (!feat_vld_o) begin
      @(negedge clk);
      waited++;
      if (waited > 200) begin
        abort_on_timeout($sformatf("no feat_vld_o for a %0d-node subgraph", n));
      end
    end
    if (expect_zero) begin
      check_feat(feat_o, '0);
    end else begin
      check_feat(feat_o, exp_feat);
    end
  endtask

  initial begin
    int waited;
    void'($urandom(32'hfc4d));
    param_we_i   <= 1'b0;
    param_sel_i  <= PARAM_W;
    param_addr_i <= '0;
    param_data_i <= '0;
    node_vld_i   <= 1'b0;
    node_feat_i  <= '0;
    node_last_i  <= 1'b0;
    pulse_cnt    <= 0;
    sent_cnt     = 0;

    waited = 0;
    while (!rst_n) begin
      @(posedge clk);
      waited++;
      if (waited > 100) begin
        abort_on_timeout("reset never released");
      end
    end

    // No result may appear while idle after reset
    repeat (20) @(posedge clk);
    check_pulse_count(pulse_cnt, 0);

    load_params(1'b0);
    for (int s = 0; s < 20; s++) begin
      run_subgraph(1, 1'b0);
    end

    // Tables reloaded every 50 subgraphs
    for (int s = 0; s < 200; s++) begin
      if (s % 50 == 0) begin
        load_params(1'b0);
      end
      run_subgraph($urandom_range(1, `GAT_MAX_NODES), 1'b0);
    end

    load_params(1'b1);
    for (int s = 0; s < 20; s++) begin
      run_subgraph($urandom_range(1, `GAT_MAX_NODES), 1'b1);
    end

    repeat (20) @(posedge clk);
    check_pulse_count(pulse_cnt, sent_cnt);
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Release lands on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== rtl/gat_layer.sv ====
`include "gat_config.svh"

module gat_layer
  import gat_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   param_we_i,
  input  param_sel_e             param_sel_i,
  input  logic [3:0]             param_addr_i,
  input  data_t                  param_data_i,
  input  logic                   node_vld_i,
  input  feat_vec_t              node_feat_i,
  input  logic                   node_last_i,
  output logic                   feat_vld_o,
  output wh_vec_t                feat_o
);

  data_t [`GAT_F_IN*`GAT_F_OUT-1:0]  w_tab;
  data_t [`GAT_F_OUT-1:0]            a_self;
  data_t [`GAT_F_OUT-1:0]            a_nbr;
  logic                              wh_vld;
  wh_vec_t                           wh;
  logic                              wh_last;
  logic                              score_vld;
  logic                              score_last;
  score_t                            score_rd;
  wh_vec_t                           wh_rd;
  logic [`GAT_NODE_IDX_W-1:0]        rd_idx;

  gat_param_store u_param_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .param_we_i   (param_we_i),
    .param_sel_i  (param_sel_i),
    .param_addr_i (param_addr_i),
    .param_data_i (param_data_i),
    .w_tab_o      (w_tab),
    .a_self_o     (a_self),
    .a_nbr_o      (a_nbr)
  );

  gat_projector u_projector (
    .clk         (clk),
    .rst_n       (rst_n),
    .node_vld_i  (node_vld_i),
    .node_feat_i (node_feat_i),
    .node_last_i (node_last_i),
    .w_tab_i     (w_tab),
    .wh_vld_o    (wh_vld),
    .wh_o        (wh),
    .wh_last_o   (wh_last)
  );

  // Score unit and Wh buffer both take the projector output
  gat_score_unit u_score_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_vld_i     (wh_vld),
    .wh_i         (wh),
    .wh_last_i    (wh_last),
    .a_self_i     (a_self),
    .a_nbr_i      (a_nbr),
    .rd_idx_i     (rd_idx),
    .score_vld_o  (score_vld),
    .score_last_o (score_last),
    .score_rd_o   (score_rd)
  );

  gat_wh_buffer u_wh_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .wh_vld_i  (wh_vld),
    .wh_i      (wh),
    .wh_last_i (wh_last),
    .rd_idx_i  (rd_idx),
    .wh_rd_o   (wh_rd)
  );

  gat_aggregator u_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .score_vld_i  (score_vld),
    .score_last_i (score_last),
    .score_rd_i   (score_rd),
    .wh_rd_i      (wh_rd),
    .rd_idx_o     (rd_idx),
    .feat_vld_o   (feat_vld_o),
    .feat_o       (feat_o)
  );

endmodule

// ==== rtl/gat_aggregator.sv ====
`include "gat_config.svh"

module gat_aggregator
  import gat_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              score_vld_i,
  input  logic                              score_last_i,
  input  score_t                            score_rd_i,
  input  wh_vec_t                           wh_rd_i,
  output logic [`GAT_NODE_IDX_W-1:0]        rd_idx_o,
  output logic                              feat_vld_o,
  output wh_vec_t                           feat_o
);

  agg_state_e                     state_q;
  logic [`GAT_NODE_IDX_W-1:0]     cnt_q;
  logic [`GAT_NODE_IDX_W-1:0]     last_idx_q;
  logic [`GAT_NODE_IDX_W-1:0]     rd_idx_q;
  logic signed [`GAT_ACC_W-1:0]   acc_q [`GAT_F_OUT];
  logic signed [`GAT_ACC_W-1:0]   sum_q;
  logic                           start;

  assign start    = (state_q == AGG_COLLECT) && score_vld_i && score_last_i;
  assign rd_idx_o = rd_idx_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= AGG_COLLECT;
      cnt_q      <= '0;
      last_idx_q <= '0;
      rd_idx_q   <= '0;
      feat_vld_o <= 1'b0;
    end else begin
      feat_vld_o <= 1'b0;
      case (state_q)
        AGG_COLLECT: begin
          if (start) begin
            last_idx_q <= cnt_q;
            cnt_q      <= '0;
            state_q    <= AGG_ACCUM;
          end else if (score_vld_i) begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        AGG_ACCUM: begin
          // One node per cycle until the last stored one
          if (rd_idx_q == last_idx_q) begin
            rd_idx_q <= '0;
            state_q  <= AGG_DIVIDE;
          end else begin
            rd_idx_q <= rd_idx_q + 1'b1;
          end
        end
        AGG_DIVIDE: begin
          feat_vld_o <= 1'b1;
          state_q    <= AGG_COLLECT;
        end
        default: begin
          state_q <= AGG_COLLECT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sum_q <= '0;
      for (int k = 0; k < `GAT_F_OUT; k++) begin
        acc_q[k] <= '0;
      end
    end else if (state_q == AGG_ACCUM) begin
      sum_q <= sum_q + $signed({1'b0, score_rd_i});
      for (int k = 0; k < `GAT_F_OUT; k++) begin
        acc_q[k] <= acc_q[k] + $signed({1'b0, score_rd_i}) * wh_rd_i.f[k];
      end
    end else if (state_q == AGG_DIVIDE) begin
      // Weighted mean, all-zero scores give a zero vector
      for (int k = 0; k < `GAT_F_OUT; k++) begin
        feat_o.f[k] <= (sum_q == 0) ? '0 : wh_t'(acc_q[k] / sum_q);
      end
    end
  end

  a_score_in_collect: assert property (@(posedge clk) disable iff (!rst_n)
    score_vld_i |-> state_q == AGG_COLLECT);

endmodule

// ==== rtl/gat_wh_buffer.sv ====
`include "gat_config.svh"

module gat_wh_buffer
  import gat_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wh_vld_i,
  input  wh_vec_t                           wh_i,
  input  logic                              wh_last_i,
  input  logic [`GAT_NODE_IDX_W-1:0]        rd_idx_i,
  output wh_vec_t                           wh_rd_o
);

  wh_vec_t                        wh_mem [`GAT_MAX_NODES];
  logic [`GAT_NODE_IDX_W-1:0]     wr_ptr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
    end else if (wh_vld_i) begin
      wr_ptr_q <= wh_last_i ? '0 : wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      wh_mem[wr_ptr_q] <= wh_i;
    end
  end

  // Replay port for the aggregator
  assign wh_rd_o = wh_mem[rd_idx_i];

  // Node 8 has to close the subgraph, a ninth write would wrap onto node 0
  a_wh_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wh_vld_i && (wr_ptr_q == `GAT_NODE_IDX_W'(`GAT_MAX_NODES - 1)) |-> wh_last_i);

endmodule

// ==== rtl/gat_score_unit.sv ====
`include "gat_config.svh"

module gat_score_unit
  import gat_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wh_vld_i,
  input  wh_vec_t                           wh_i,
  input  logic                              wh_last_i,
  input  data_t [`GAT_F_OUT-1:0]            a_self_i,
  input  data_t [`GAT_F_OUT-1:0]            a_nbr_i,
  input  logic [`GAT_NODE_IDX_W-1:0]        rd_idx_i,
  output logic                              score_vld_o,
  output logic                              score_last_o,
  output score_t                            score_rd_o
);

  logic signed [`GAT_SCORE_W-1:0] self_now;
  logic signed [`GAT_SCORE_W-1:0] self_q;
  logic signed [`GAT_SCORE_W-1:0] nbr_now;
  logic signed [`GAT_SCORE_W-1:0] raw;
  score_t                         score_d;
  score_t                         score_mem [`GAT_MAX_NODES];
  logic [`GAT_NODE_IDX_W-1:0]     wr_ptr_q;
  logic                           first_q;

  always_comb begin
    self_now = '0;
    nbr_now  = '0;
    for (int k = 0; k < `GAT_F_OUT; k++) begin
      self_now = self_now + a_self_i[k] * wh_i.f[k];
      nbr_now  = nbr_now + a_nbr_i[k] * wh_i.f[k];
    end
    // Target node supplies its own self term
    raw     = (first_q ? self_now : self_q) + nbr_now;
    score_d = (raw < 0) ? '0 : score_t'(raw);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q      <= 1'b1;
      wr_ptr_q     <= '0;
      score_vld_o  <= 1'b0;
      score_last_o <= 1'b0;
    end else begin
      score_vld_o  <= wh_vld_i;
      score_last_o <= wh_vld_i & wh_last_i;
      if (wh_vld_i) begin
        first_q  <= wh_last_i;
        wr_ptr_q <= wh_last_i ? '0 : wr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      score_mem[wr_ptr_q] <= score_d;
      if (first_q) begin
        self_q <= self_now;
      end
    end
  end

  assign score_rd_o = score_mem[rd_idx_i];

  // Aggregator idles at index 0 while scores arrive
  a_score_pos: assert property (@(posedge clk) disable iff (!rst_n)
    score_vld_o |-> !score_rd_o[`GAT_SCORE_W-1]);

endmodule

// ==== rtl/gat_projector.sv ====
`include "gat_config.svh"

module gat_projector
  import gat_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   node_vld_i,
  input  feat_vec_t                              node_feat_i,
  input  logic                                   node_last_i,
  input  data_t [`GAT_F_IN*`GAT_F_OUT-1:0]       w_tab_i,
  output logic                                   wh_vld_o,
  output wh_vec_t                                wh_o,
  output logic                                   wh_last_o
);

  wh_vec_t wh_d;

  // One dot product per output feature, h times column k of W
  always_comb begin
    for (int k = 0; k < `GAT_F_OUT; k++) begin
      wh_d.f[k] = '0;
      for (int i = 0; i < `GAT_F_IN; i++) begin
        wh_d.f[k] = wh_d.f[k] + node_feat_i.f[i] * w_tab_i[i*`GAT_F_OUT + k];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_o  <= 1'b0;
      wh_last_o <= 1'b0;
    end else begin
      wh_vld_o  <= node_vld_i;
      wh_last_o <= node_vld_i & node_last_i;
    end
  end

  // Result only moves with a node strobe
  always_ff @(posedge clk) begin
    if (node_vld_i) begin
      wh_o <= wh_d;
    end
  end

endmodule

// ==== rtl/gat_param_store.sv ====
`include "gat_config.svh"

module gat_param_store
  import gat_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   param_we_i,
  input  param_sel_e                             param_sel_i,
  input  logic [3:0]                             param_addr_i,
  input  data_t                                  param_data_i,
  output data_t [`GAT_F_IN*`GAT_F_OUT-1:0]       w_tab_o,
  output data_t [`GAT_F_OUT-1:0]                 a_self_o,
  output data_t [`GAT_F_OUT-1:0]                 a_nbr_o
);

  // W is flat, row i and column k at i*F_OUT + k
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_tab_o  <= '0;
      a_self_o <= '0;
      a_nbr_o  <= '0;
    end else if (param_we_i) begin
      case (param_sel_i)
        PARAM_W: begin
          w_tab_o[param_addr_i] <= param_data_i;
        end
        PARAM_A_SELF: begin
          a_self_o[param_addr_i[1:0]] <= param_data_i;
        end
        PARAM_A_NBR: begin
          a_nbr_o[param_addr_i[1:0]] <= param_data_i;
        end
        default: begin
        end
      endcase
    end
  end

  // Attention tables only have F_OUT entries
  a_attn_addr: assert property (@(posedge clk) disable iff (!rst_n)
    param_we_i && (param_sel_i != PARAM_W) |-> param_addr_i < `GAT_F_OUT);

endmodule

// ==== rtl/gat_pkg.sv ====
`include "gat_config.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic signed [`GAT_WH_W-1:0] wh_t;
  // Scores are clamped by the ReLU, so the top bit stays clear
  typedef logic [`GAT_SCORE_W-1:0] score_t;

  // One input node
  typedef struct packed {
    data_t [`GAT_F_IN-1:0] f;
  } feat_vec_t;

  // Projected node, also the layer result
  typedef struct packed {
    wh_t [`GAT_F_OUT-1:0] f;
  } wh_vec_t;

  typedef enum logic [1:0] {
    PARAM_W,
    PARAM_A_SELF,
    PARAM_A_NBR
  } param_sel_e;

  typedef enum logic [1:0] {
    AGG_COLLECT,
    AGG_ACCUM,
    AGG_DIVIDE
  } agg_state_e;

endpackage

// ==== include/gat_config.svh ====
`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// Feature counts of the single attention head
`define GAT_F_IN        4
`define GAT_F_OUT       4

// Largest subgraph and the index that walks it
`define GAT_MAX_NODES   8
`define GAT_NODE_IDX_W  3

// Datapath widths
`define GAT_DATA_W      8
`define GAT_WH_W        18
`define GAT_SCORE_W     32
`define GAT_ACC_W       56

`endif
